//--- Makefile
# Verilator build and run of the GPIO subsystem testbench

LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run, and fail if the log reports failure"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module gpio_tb \
		-f sim.f -o Vgpio_tb
	./obj_dir/Vgpio_tb > $(LOG) 2>&1 || (cat $(LOG); exit 1)
	@cat $(LOG)
	@if grep -q "STATUS: FAIL" $(LOG); then exit 1; fi

clean:
	rm -rf obj_dir $(LOG)

//--- logic/apb_pkg.sv
// APB types for the peripheral bus
// address and data words, request and response structs
package apb_pkg;

  ////////////////////////////////////////
  // widths
  ////////////////////////////////////////

  // byte address, enough for one peripheral window
  localparam int ADDR_W = 8;
  localparam int DATA_W = 32;

  typedef logic [ADDR_W-1:0] apb_addr_t;
  typedef logic [DATA_W-1:0] apb_data_t;

  ////////////////////////////////////////
  // bus structs
  ////////////////////////////////////////

  // manager to subordinate
  typedef struct packed {
    logic      psel;
    logic      penable;
    logic      pwrite;
    apb_addr_t paddr;
    apb_data_t pwdata;
  } apb_req_t;

  // subordinate to manager
  typedef struct packed {
    logic      pready;
    apb_data_t prdata;
    logic      pslverr;
  } apb_rsp_t;

endpackage : apb_pkg

//--- logic/gpio_apb_regs.sv
// GPIO APB register file
// output, enable and mask registers, sticky overflow flag,
// read mux, error decode and event pop on read
`timescale 1ns/1ps

module gpio_apb_regs (
  input  logic                  clk,
  input  logic                  reset,
  // APB
  input  apb_pkg::apb_req_t     apb_req,
  output apb_pkg::apb_rsp_t     apb_rsp,
  // pins
  input  gpio_pkg::gpio_vec_t   sync_in,
  output gpio_pkg::gpio_vec_t   pad_out,
  output gpio_pkg::gpio_vec_t   pad_oe,
  // edge masks to the capture block
  output gpio_pkg::gpio_vec_t   rise_en,
  output gpio_pkg::gpio_vec_t   fall_en,
  // event queue head
  input  logic                  head_valid,
  input  gpio_pkg::gpio_event_t head,
  output logic                  pop,
  // status inputs
  input  gpio_pkg::fifo_cnt_t   count,
  input  logic                  overflow
);

  gpio_pkg::gpio_vec_t out_q;
  gpio_pkg::gpio_vec_t oe_q;
  gpio_pkg::gpio_vec_t rise_en_q;
  gpio_pkg::gpio_vec_t fall_en_q;
  logic                ovf_q;
  apb_pkg::apb_data_t  rdata;
  logic                access;
  logic                mapped;
  logic                read_only;
  logic                wr_ok;
  logic                ovf_clr;

  // access phase, pready is tied high so this is the last cycle
  assign access = apb_req.psel && apb_req.penable;

  ////////////////////////////////////////
  // decode and read mux
  ////////////////////////////////////////

  always_comb begin
    rdata     = '0;
    mapped    = 1'b1;
    read_only = 1'b0;
    case (apb_req.paddr)
      gpio_pkg::REG_OUT:     rdata = out_q;
      gpio_pkg::REG_OE:      rdata = oe_q;
      gpio_pkg::REG_RISE_EN: rdata = rise_en_q;
      gpio_pkg::REG_FALL_EN: rdata = fall_en_q;
      gpio_pkg::REG_IN: begin
        rdata     = sync_in;
        read_only = 1'b1;
      end
      gpio_pkg::REG_EVENT: begin
        read_only = 1'b1;
        // empty queue reads as all zero
        if (head_valid) begin
          rdata[gpio_pkg::EVT_VALID_BIT]   = 1'b1;
          rdata[gpio_pkg::EVT_EDGE_BIT]    = head.rising;
          rdata[gpio_pkg::PIN_W-1:0]       = head.pin;
        end
      end
      gpio_pkg::REG_STATUS: begin
        rdata[gpio_pkg::STATUS_OVF_BIT]           = ovf_q;
        rdata[$bits(gpio_pkg::fifo_cnt_t)-1:0]    = count;
      end
      default: mapped = 1'b0;
    endcase
  end

  assign wr_ok   = access && apb_req.pwrite && mapped && !read_only;
  assign ovf_clr = wr_ok && (apb_req.paddr == gpio_pkg::REG_STATUS) &&
                   apb_req.pwdata[gpio_pkg::STATUS_OVF_BIT];

  // pop on the access cycle of an event read
  assign pop = access && !apb_req.pwrite &&
               (apb_req.paddr == gpio_pkg::REG_EVENT) && head_valid;

  ////////////////////////////////////////
  // response
  ////////////////////////////////////////

  assign apb_rsp.pready  = 1'b1;
  assign apb_rsp.prdata  = (access && !apb_req.pwrite) ? rdata : '0;
  assign apb_rsp.pslverr = access && (!mapped || (apb_req.pwrite && read_only));

  ////////////////////////////////////////
  // writable registers
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      out_q     <= '0;
      oe_q      <= '0;
      rise_en_q <= '0;
      fall_en_q <= '0;
    end else if (wr_ok) begin
      case (apb_req.paddr)
        gpio_pkg::REG_OUT:     out_q     <= apb_req.pwdata;
        gpio_pkg::REG_OE:      oe_q      <= apb_req.pwdata;
        gpio_pkg::REG_RISE_EN: rise_en_q <= apb_req.pwdata;
        gpio_pkg::REG_FALL_EN: fall_en_q <= apb_req.pwdata;
        // status write only touches the sticky flag
        default: ;
      endcase
    end
  end

  // sticky flag, a new overflow beats the clear
  always_ff @(posedge clk) begin
    if (reset) begin
      ovf_q <= 1'b0;
    end else begin
      ovf_q <= overflow || (ovf_q && !ovf_clr);
    end
  end

  assign pad_out = out_q;
  assign pad_oe  = oe_q;
  assign rise_en = rise_en_q;
  assign fall_en = fall_en_q;

  // manager side protocol
  a_penable_psel : assert property (@(posedge clk) disable iff (reset)
    apb_req.penable |-> apb_req.psel);

endmodule : gpio_apb_regs

//--- logic/gpio_edge_capture.sv
// GPIO input path
// two-flop synchronizer, edge detection, pending edge masks
// and a lowest-pin-first encoder feeding the event FIFO
`timescale 1ns/1ps

module gpio_edge_capture (
  input  logic                  clk,
  input  logic                  reset,
  // pads and edge masks
  input  gpio_pkg::gpio_vec_t   pad_in,
  input  gpio_pkg::gpio_vec_t   rise_en,
  input  gpio_pkg::gpio_vec_t   fall_en,
  // synchronized input
  output gpio_pkg::gpio_vec_t   sync_in,
  // event stream into the FIFO
  output logic                  evt_valid,
  output gpio_pkg::gpio_event_t evt,
  input  logic                  evt_ready,
  // edge merged into an already pending one
  output logic                  overflow
);

  // synchronizer and previous sample
  gpio_pkg::gpio_vec_t   meta_q;
  gpio_pkg::gpio_vec_t   sync_q;
  gpio_pkg::gpio_vec_t   prev_q;
  // edge detection and pending masks
  gpio_pkg::gpio_vec_t   rise_set;
  gpio_pkg::gpio_vec_t   fall_set;
  gpio_pkg::gpio_vec_t   rise_clr;
  gpio_pkg::gpio_vec_t   fall_clr;
  gpio_pkg::gpio_vec_t   rise_pend;
  gpio_pkg::gpio_vec_t   fall_pend;
  // encoder and stall hold
  gpio_pkg::gpio_event_t enc_evt;
  gpio_pkg::gpio_event_t hold_evt_q;
  logic                  enc_found;
  logic                  hold_q;
  logic                  xfer;

  ////////////////////////////////////////
  // synchronizer
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      meta_q <= '0;
      sync_q <= '0;
      prev_q <= '0;
    end else begin
      meta_q <= pad_in;
      sync_q <= meta_q;
      prev_q <= sync_q;
    end
  end

  assign sync_in = sync_q;

  // masked edges, one cycle after the synchronized value moves
  assign rise_set = sync_q & ~prev_q & rise_en;
  assign fall_set = ~sync_q & prev_q & fall_en;

  ////////////////////////////////////////
  // pending masks
  ////////////////////////////////////////

  assign xfer = evt_valid && evt_ready;

  // clear only the bit whose event went into the FIFO
  always_comb begin
    rise_clr = '0;
    fall_clr = '0;
    if (xfer) begin
      if (evt.rising) begin
        rise_clr[evt.pin] = 1'b1;
      end else begin
        fall_clr[evt.pin] = 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      rise_pend <= '0;
      fall_pend <= '0;
    end else begin
      // a new edge wins over the clear of the same bit
      rise_pend <= (rise_pend & ~rise_clr) | rise_set;
      fall_pend <= (fall_pend & ~fall_clr) | fall_set;
    end
  end

  // edge lands on a bit that stays pending
  assign overflow = |(rise_set & rise_pend & ~rise_clr) |
                    |(fall_set & fall_pend & ~fall_clr);

  ////////////////////////////////////////
  // priority encoder
  ////////////////////////////////////////

  // walk down so the lowest pin is the last one written
  always_comb begin
    enc_found      = 1'b0;
    enc_evt.pin    = '0;
    enc_evt.rising = 1'b0;
    for (int i = gpio_pkg::GPIO_W - 1; i >= 0; i--) begin
      if (rise_pend[i] || fall_pend[i]) begin
        enc_found      = 1'b1;
        enc_evt.pin    = gpio_pkg::pin_idx_t'(i);
        // rising first when both are pending
        enc_evt.rising = rise_pend[i];
      end
    end
  end

  // offered event is frozen while the FIFO stalls it
  always_ff @(posedge clk) begin
    if (reset) begin
      hold_q <= 1'b0;
    end else begin
      hold_q <= evt_valid && !evt_ready;
    end
  end

  always_ff @(posedge clk) begin
    hold_evt_q <= evt;
  end

  assign evt_valid = hold_q || enc_found;
  assign evt       = hold_q ? hold_evt_q : enc_evt;

  // stalled offer keeps its value until the FIFO takes it
  a_evt_stable : assert property (@(posedge clk) disable iff (reset)
    evt_valid && !evt_ready |=> evt_valid && $stable(evt));

endmodule : gpio_edge_capture

//--- logic/gpio_event_fifo.sv
// GPIO event FIFO
// circular buffer with occupancy count, push and pop in one cycle allowed
`timescale 1ns/1ps

module gpio_event_fifo (
  input  logic                  clk,
  input  logic                  reset,
  // write side from the edge capture
  input  logic                  evt_valid,
  input  gpio_pkg::gpio_event_t evt,
  output logic                  evt_ready,
  // read side to the register block
  output logic                  head_valid,
  output gpio_pkg::gpio_event_t head,
  input  logic                  pop,
  // occupancy
  output gpio_pkg::fifo_cnt_t   count
);

  gpio_pkg::gpio_event_t mem [gpio_pkg::FIFO_DEPTH];
  gpio_pkg::fifo_ptr_t   wr_ptr;
  gpio_pkg::fifo_ptr_t   rd_ptr;
  gpio_pkg::fifo_cnt_t   cnt_q;
  logic                  push;

  ////////////////////////////////////////
  // flags
  ////////////////////////////////////////

  assign evt_ready  = cnt_q != gpio_pkg::fifo_cnt_t'(gpio_pkg::FIFO_DEPTH);
  assign head_valid = cnt_q != '0;
  assign push       = evt_valid && evt_ready;
  assign count      = cnt_q;

  // payload storage
  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= evt;
    end
  end

  assign head = mem[rd_ptr];

  // pointers wrap on their own since the depth is a power of two
  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      cnt_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   cnt_q <= cnt_q + 1'b1;
        2'b01:   cnt_q <= cnt_q - 1'b1;
        default: cnt_q <= cnt_q;
      endcase
    end
  end

  // register block only pops a valid head
  a_no_pop_empty : assert property (@(posedge clk) disable iff (reset)
    pop |-> head_valid);

  a_cnt_bound : assert property (@(posedge clk) disable iff (reset)
    cnt_q <= gpio_pkg::fifo_cnt_t'(gpio_pkg::FIFO_DEPTH));

endmodule : gpio_event_fifo

//--- logic/gpio_pkg.sv
// GPIO definitions
// pin widths, event struct, FIFO sizing, register map and field positions
package gpio_pkg;

  ////////////////////////////////////////
  // pins
  ////////////////////////////////////////

  localparam int GPIO_W = 32;
  localparam int PIN_W  = $clog2(GPIO_W);

  // one bit per pin
  typedef logic [GPIO_W-1:0] gpio_vec_t;
  typedef logic [PIN_W-1:0]  pin_idx_t;

  // queued edge, rising is 1 for a rising edge
  typedef struct packed {
    pin_idx_t pin;
    logic     rising;
  } gpio_event_t;

  ////////////////////////////////////////
  // event FIFO
  ////////////////////////////////////////

  localparam int FIFO_DEPTH = 8;
  localparam int FIFO_AW    = $clog2(FIFO_DEPTH);

  typedef logic [FIFO_AW-1:0] fifo_ptr_t;
  // one extra bit so a full FIFO can be counted
  typedef logic [FIFO_AW:0]   fifo_cnt_t;

  ////////////////////////////////////////
  // register map
  ////////////////////////////////////////

  localparam apb_pkg::apb_addr_t REG_OUT     = 8'h00;
  localparam apb_pkg::apb_addr_t REG_OE      = 8'h04;
  localparam apb_pkg::apb_addr_t REG_IN      = 8'h08;
  localparam apb_pkg::apb_addr_t REG_RISE_EN = 8'h0C;
  localparam apb_pkg::apb_addr_t REG_FALL_EN = 8'h10;
  localparam apb_pkg::apb_addr_t REG_EVENT   = 8'h14;
  localparam apb_pkg::apb_addr_t REG_STATUS  = 8'h18;

  // field positions inside REG_EVENT and REG_STATUS
  localparam int EVT_VALID_BIT  = 31;
  localparam int EVT_EDGE_BIT   = 8;
  localparam int STATUS_OVF_BIT = 8;

endpackage : gpio_pkg

//--- logic/gpio_subsys_top.sv
// GPIO subsystem top
// edge capture into the event FIFO, drained by the APB register block
`timescale 1ns/1ps

module gpio_subsys_top (
  input  logic                clk,
  input  logic                reset,
  // APB
  input  apb_pkg::apb_req_t   apb_req,
  output apb_pkg::apb_rsp_t   apb_rsp,
  // pads, tristate handled outside
  input  gpio_pkg::gpio_vec_t pad_in,
  output gpio_pkg::gpio_vec_t pad_out,
  output gpio_pkg::gpio_vec_t pad_oe
);

  // capture to registers
  gpio_pkg::gpio_vec_t   sync_in;
  gpio_pkg::gpio_vec_t   rise_en;
  gpio_pkg::gpio_vec_t   fall_en;
  logic                  overflow;
  // capture to FIFO
  logic                  evt_valid;
  logic                  evt_ready;
  gpio_pkg::gpio_event_t evt;
  // FIFO to registers
  logic                  head_valid;
  gpio_pkg::gpio_event_t head;
  logic                  pop;
  gpio_pkg::fifo_cnt_t   count;

  ////////////////////////////////////////
  // producer, buffer, consumer
  ////////////////////////////////////////

  gpio_edge_capture u_capture (
    .clk       (clk),
    .reset     (reset),
    .pad_in    (pad_in),
    .rise_en   (rise_en),
    .fall_en   (fall_en),
    .sync_in   (sync_in),
    .evt_valid (evt_valid),
    .evt       (evt),
    .evt_ready (evt_ready),
    .overflow  (overflow)
  );

  gpio_event_fifo u_fifo (
    .clk        (clk),
    .reset      (reset),
    .evt_valid  (evt_valid),
    .evt        (evt),
    .evt_ready  (evt_ready),
    .head_valid (head_valid),
    .head       (head),
    .pop        (pop),
    .count      (count)
  );

  gpio_apb_regs u_regs (
    .clk        (clk),
    .reset      (reset),
    .apb_req    (apb_req),
    .apb_rsp    (apb_rsp),
    .sync_in    (sync_in),
    .pad_out    (pad_out),
    .pad_oe     (pad_oe),
    .rise_en    (rise_en),
    .fall_en    (fall_en),
    .head_valid (head_valid),
    .head       (head),
    .pop        (pop),
    .count      (count),
    .overflow   (overflow)
  );

endmodule : gpio_subsys_top

//--- sim.f
logic/apb_pkg.sv
logic/gpio_pkg.sv
logic/gpio_edge_capture.sv
logic/gpio_event_fifo.sv
logic/gpio_apb_regs.sv
logic/gpio_subsys_top.sv
verif/gpio_tb.sv

//--- verif/gpio_tb.sv
// GPIO subsystem testbench
// clock, reset, LFSR stimulus, APB manager tasks
// register and event queue model, five directed-random tests
`timescale 1ns/1ps

module gpio_tb;

  localparam logic [31:0] LFSR_SEED = 32'hd20c649f;
  // x^32 + x^22 + x^2 + x + 1
  localparam logic [31:0] LFSR_TAPS = 32'h80200003;
  // bound well above the summed length of the five tests
  localparam int TIMEOUT_CYCLES = 6000;

  logic                clk;
  logic                reset;
  apb_pkg::apb_req_t   apb_req;
  apb_pkg::apb_rsp_t   apb_rsp;
  gpio_pkg::gpio_vec_t pad_in;
  gpio_pkg::gpio_vec_t pad_out;
  gpio_pkg::gpio_vec_t pad_oe;

  // model state
  logic [31:0] lfsr_q;
  logic [31:0] model_out;
  logic [31:0] model_oe;
  logic [31:0] rise_m;
  logic [31:0] fall_m;
  logic [31:0] pad_q;
  logic        model_ovf;
  logic [31:0] exp_q[$];
  int          cycles = 0;
  int          errors = 0;
  int          checks = 0;
  int          err_mark = 0;
  int          tests_pass = 0;
  int          tests_fail = 0;

  gpio_subsys_top dut_i (
    .clk     (clk),
    .reset   (reset),
    .apb_req (apb_req),
    .apb_rsp (apb_rsp),
    .pad_in  (pad_in),
    .pad_out (pad_out),
    .pad_oe  (pad_oe)
  );

  always #20 clk = ~clk;

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("STATUS: FAIL");
      $finish;
    end
  end

  ////////////////////////////////////////
  // helpers
  ////////////////////////////////////////

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
  endfunction

  // one LFSR step per bit taken
  function logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr_q[0]};
      lfsr_q = lfsr_next(lfsr_q);
    end
    return v;
  endfunction

  // valid at 31 and edge at 8 with the pin in 4:0
  function automatic logic [31:0] event_word(input logic [4:0] pin, input logic rising);
    logic [31:0] w;
    w = '0;
    w[31] = 1'b1;
    w[8] = rising;
    w[4:0] = pin;
    return w;
  endfunction

  // count in 3:0 saturates at the depth and the sticky flag sits at 8
  function automatic logic [31:0] status_word(input int queued, input logic ovf);
    logic [31:0] w;
    w = '0;
    w[8] = ovf;
    w[3:0] = (queued > 8) ? 4'd8 : queued[3:0];
    return w;
  endfunction

  function automatic logic is_mapped(input apb_pkg::apb_addr_t a);
    return a inside {gpio_pkg::REG_OUT, gpio_pkg::REG_OE, gpio_pkg::REG_IN,
                     gpio_pkg::REG_RISE_EN, gpio_pkg::REG_FALL_EN,
                     gpio_pkg::REG_EVENT, gpio_pkg::REG_STATUS};
  endfunction

  task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      $display("ERROR t=%0t %s got %h expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  // setup and access phases with the response sampled mid-cycle
  task automatic apb_xfer(input logic write, input apb_pkg::apb_addr_t addr,
                          input apb_pkg::apb_data_t wdata,
                          output apb_pkg::apb_data_t rdata, output logic err);
    @(posedge clk);
    apb_req.psel    <= 1'b1;
    apb_req.penable <= 1'b0;
    apb_req.pwrite  <= write;
    apb_req.paddr   <= addr;
    apb_req.pwdata  <= wdata;
    @(posedge clk);
    apb_req.penable <= 1'b1;
    @(negedge clk);
    rdata = apb_rsp.prdata;
    err = apb_rsp.pslverr;
    check_eq("pready", {31'b0, apb_rsp.pready}, 32'h1);
    @(posedge clk);
    apb_req.psel    <= 1'b0;
    apb_req.penable <= 1'b0;
  endtask

  task automatic apb_write(input apb_pkg::apb_addr_t addr, input apb_pkg::apb_data_t data,
                           input logic exp_err);
    apb_pkg::apb_data_t rd;
    logic err;
    apb_xfer(1'b1, addr, data, rd, err);
    check_eq("pslverr", {31'b0, err}, {31'b0, exp_err});
  endtask

  task automatic read_expect(input apb_pkg::apb_addr_t addr, input logic [31:0] exp,
                             input string name);
    apb_pkg::apb_data_t got;
    logic err;
    apb_xfer(1'b0, addr, '0, got, err);
    check_eq(name, got, exp);
    check_eq("pslverr", {31'b0, err}, 32'h0);
  endtask

  // flip one pad and queue or merge the masked edge
  task automatic toggle_pin(input gpio_pkg::pin_idx_t p);
    logic        rising;
    logic        merged;
    logic [31:0] ev;
    rising = !pad_q[p];
    pad_q[p] = rising;
    @(posedge clk);
    pad_in <= pad_q;
    if (rising ? rise_m[p] : fall_m[p]) begin
      ev = event_word(p, rising);
      merged = 1'b0;
      // entries past the depth are still pending in the capture block
      for (int i = gpio_pkg::FIFO_DEPTH; i < exp_q.size(); i++) begin
        if (exp_q[i] == ev) begin
          merged = 1'b1;
        end
      end
      if (merged) begin
        model_ovf = 1'b1;
      end else begin
        exp_q.push_back(ev);
      end
    end
    repeat (6) @(posedge clk);
  endtask

  task automatic drain_events();
    while (exp_q.size() > 0) begin
      read_expect(gpio_pkg::REG_EVENT, exp_q.pop_front(), "reg_event");
    end
    read_expect(gpio_pkg::REG_EVENT, 32'h0, "reg_event empty");
  endtask

  task automatic finish_test(input string name);
    if (errors == err_mark) begin
      tests_pass++;
      $display("test %s passed", name);
    end else begin
      tests_fail++;
      $display("test %s failed with %0d errors", name, errors - err_mark);
    end
    err_mark = errors;
  endtask

  ////////////////////////////////////////
  // tests
  ////////////////////////////////////////

  initial begin
    apb_pkg::apb_data_t  got;
    apb_pkg::apb_addr_t  addr;
    logic                err;
    clk = 1'b0;
    reset = 1'b1;
    apb_req = '0;
    pad_in = '0;
    pad_q = '0;
    lfsr_q = LFSR_SEED;
    model_out = '0;
    model_oe = '0;
    rise_m = '0;
    fall_m = '0;
    model_ovf = 1'b0;
    repeat (4) @(posedge clk);
    reset <= 1'b0;

    // output and enable registers with reset values first
    read_expect(gpio_pkg::REG_OUT, 32'h0, "reg_out");
    read_expect(gpio_pkg::REG_OE, 32'h0, "reg_oe");
    check_eq("pad_out", pad_out, 32'h0);
    check_eq("pad_oe", pad_oe, 32'h0);
    for (int n = 0; n < 8; n++) begin
      model_out = rand_bits(32);
      model_oe = rand_bits(32);
      apb_write(gpio_pkg::REG_OUT, model_out, 1'b0);
      apb_write(gpio_pkg::REG_OE, model_oe, 1'b0);
      @(negedge clk);
      check_eq("pad_out", pad_out, model_out);
      check_eq("pad_oe", pad_oe, model_oe);
      read_expect(gpio_pkg::REG_OUT, model_out, "reg_out");
      read_expect(gpio_pkg::REG_OE, model_oe, "reg_oe");
    end
    finish_test("out_oe");

    // masks still zero so these pads raise no events
    for (int n = 0; n < 8; n++) begin
      pad_q = rand_bits(32);
      @(posedge clk);
      pad_in <= pad_q;
      repeat (4) @(posedge clk);
      read_expect(gpio_pkg::REG_IN, pad_q, "reg_in");
    end
    finish_test("input_sync");

    // single toggles under random masks with fewer events than a full FIFO
    rise_m = rand_bits(32);
    fall_m = rand_bits(32);
    apb_write(gpio_pkg::REG_RISE_EN, rise_m, 1'b0);
    apb_write(gpio_pkg::REG_FALL_EN, fall_m, 1'b0);
    for (int n = 0; n < 12 && exp_q.size() < 7; n++) begin
      toggle_pin(gpio_pkg::pin_idx_t'(rand_bits(5)));
    end
    drain_events();
    finish_test("edge_events");

    // quiet pads at zero before enabling rising edges only
    rise_m = '0;
    fall_m = '0;
    apb_write(gpio_pkg::REG_RISE_EN, rise_m, 1'b0);
    apb_write(gpio_pkg::REG_FALL_EN, fall_m, 1'b0);
    pad_q = '0;
    @(posedge clk);
    pad_in <= pad_q;
    repeat (6) @(posedge clk);
    rise_m = '1;
    apb_write(gpio_pkg::REG_RISE_EN, rise_m, 1'b0);
    for (int p = 0; p < 8; p++) begin
      toggle_pin(gpio_pkg::pin_idx_t'(p));
    end
    // lower pin first so it becomes the stalled offer
    toggle_pin(gpio_pkg::pin_idx_t'(12));
    toggle_pin(gpio_pkg::pin_idx_t'(20));
    // masked fall followed by a rise that merges
    toggle_pin(gpio_pkg::pin_idx_t'(20));
    toggle_pin(gpio_pkg::pin_idx_t'(20));
    read_expect(gpio_pkg::REG_STATUS, status_word(exp_q.size(), model_ovf), "reg_status");
    drain_events();
    read_expect(gpio_pkg::REG_STATUS, status_word(0, model_ovf), "reg_status");
    apb_write(gpio_pkg::REG_STATUS, 32'h100, 1'b0);
    model_ovf = 1'b0;
    read_expect(gpio_pkg::REG_STATUS, status_word(0, model_ovf), "reg_status");
    finish_test("overflow");

    // error responses leave every register alone
    for (int n = 0; n < 6; n++) begin
      addr = apb_pkg::apb_addr_t'(rand_bits(8));
      while (is_mapped(addr)) begin
        addr = apb_pkg::apb_addr_t'(rand_bits(8));
      end
      apb_write(addr, rand_bits(32), 1'b1);
      apb_xfer(1'b0, addr, '0, got, err);
      check_eq("pslverr", {31'b0, err}, 32'h1);
    end
    apb_write(gpio_pkg::REG_IN, rand_bits(32), 1'b1);
    apb_write(gpio_pkg::REG_EVENT, rand_bits(32), 1'b1);
    read_expect(gpio_pkg::REG_OUT, model_out, "reg_out");
    read_expect(gpio_pkg::REG_OE, model_oe, "reg_oe");
    read_expect(gpio_pkg::REG_RISE_EN, rise_m, "reg_rise_en");
    read_expect(gpio_pkg::REG_FALL_EN, fall_m, "reg_fall_en");
    read_expect(gpio_pkg::REG_IN, pad_q, "reg_in");
    read_expect(gpio_pkg::REG_STATUS, status_word(0, model_ovf), "reg_status");
    finish_test("slave_error");

    $display("tests passed %0d failed %0d, checks %0d, errors %0d",
             tests_pass, tests_fail, checks, errors);
    if (errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule : gpio_tb
